// ==== fir_accel.f ====
+incdir+tests
src/fir_pkg.sv
src/word_ram.sv
src/axil_regs.sv
src/fir_engine.sv
src/fir_top.sv
tests/fir_tb.sv

// ==== src/axil_regs.sv ====
`timescale 1ns/10ps

module axil_regs (
    input  logic               axis_clk,
    input  logic               axis_rst_n,
    input  logic               awvalid,
    output logic               awready,
    input  logic               wvalid,
    output logic               wready,
    input  fir_pkg::addr_t     awaddr,
    input  fir_pkg::data_t     wdata,
    input  logic               arvalid,
    output logic               arready,
    input  fir_pkg::addr_t     araddr,
    output logic               rvalid,
    input  logic               rready,
    output fir_pkg::data_t     rdata,
    input  logic               done,
    output logic               start,
    output fir_pkg::data_t     data_length,
    output fir_pkg::tap_cnt_t  tap_num,
    output logic               tap_we,
    output fir_pkg::tap_idx_t  tap_waddr,
    output fir_pkg::data_t     tap_wdata
);

    fir_pkg::ctrl_state_e state;
    fir_pkg::addr_t       rd_addr;
    logic                 wr_fire;
    logic                 cfg_open;
    logic                 tap_hit;
    logic                 ctrl_read_done;

    // write channel, both readies pulse one cycle after valids
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !wready;
            wready  <= awvalid && wvalid && !wready;
        end
    end

    assign wr_fire  = awvalid && wvalid && awready && wready;
    assign cfg_open = (state == fir_pkg::CTRL_IDLE);
    assign tap_hit  = (awaddr >= fir_pkg::ADDR_TAP_BASE) && (awaddr <= fir_pkg::ADDR_TAP_LAST);

    // coefficient writes go straight to the tap ram
    assign tap_we    = wr_fire && cfg_open && tap_hit;
    assign tap_waddr = awaddr[6:2];
    assign tap_wdata = wdata;

    assign start = wr_fire && cfg_open && (awaddr == fir_pkg::ADDR_AP_CTRL)
                   && wdata[fir_pkg::AP_START_BIT];

    // read channel, arready pulse then rvalid held until rready
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (arvalid && arready) begin
            rd_addr <= araddr;
        end
    end

    // read decode
    always_comb begin
        case (rd_addr)
            fir_pkg::ADDR_AP_CTRL: begin
                rdata = '0;
                rdata[fir_pkg::AP_DONE_BIT] = (state == fir_pkg::CTRL_DONE);
                rdata[fir_pkg::AP_IDLE_BIT] = (state == fir_pkg::CTRL_IDLE);
            end
            fir_pkg::ADDR_DATA_LEN: begin
                rdata = data_length;
            end
            fir_pkg::ADDR_TAP_NUM: begin
                rdata = fir_pkg::data_t'(tap_num);
            end
            default: begin
                rdata = fir_pkg::RDATA_NONE;
            end
        endcase
    end

    assign ctrl_read_done = rvalid && rready && (rd_addr == fir_pkg::ADDR_AP_CTRL);

    // configuration registers, frozen outside idle
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            data_length <= '0;
            tap_num     <= '0;
        end else if (wr_fire && cfg_open) begin
            if (awaddr == fir_pkg::ADDR_DATA_LEN) begin
                data_length <= wdata;
            end
            if (awaddr == fir_pkg::ADDR_TAP_NUM) begin
                tap_num <= fir_pkg::tap_cnt_t'(wdata);
            end
        end
    end

    // run control
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state <= fir_pkg::CTRL_IDLE;
        end else begin
            case (state)
                fir_pkg::CTRL_IDLE: begin
                    if (start) begin
                        state <= fir_pkg::CTRL_RUN;
                    end
                end
                fir_pkg::CTRL_RUN: begin
                    if (done) begin
                        state <= fir_pkg::CTRL_DONE;
                    end
                end
                fir_pkg::CTRL_DONE: begin
                    // done is cleared once software has seen it
                    if (ctrl_read_done) begin
                        state <= fir_pkg::CTRL_IDLE;
                    end
                end
                default: begin
                    state <= fir_pkg::CTRL_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== src/fir_engine.sv ====
`timescale 1ns/10ps

module fir_engine (
    input  logic               axis_clk,
    input  logic               axis_rst_n,
    input  logic               start,
    input  fir_pkg::data_t     data_length,
    input  fir_pkg::tap_cnt_t  tap_num,
    output logic               done,
    output fir_pkg::tap_idx_t  tap_raddr,
    input  fir_pkg::data_t     tap_rdata,
    output logic               x_we,
    output fir_pkg::tap_idx_t  x_waddr,
    output fir_pkg::data_t     x_wdata,
    output fir_pkg::tap_idx_t  x_raddr,
    input  fir_pkg::data_t     x_rdata,
    input  logic               ss_tvalid,
    output logic               ss_tready,
    input  fir_pkg::data_t     ss_tdata,
    output logic               sm_tvalid,
    input  logic               sm_tready,
    output fir_pkg::data_t     sm_tdata,
    output logic               sm_tlast
);

    fir_pkg::engine_state_e     state;
    fir_pkg::tap_idx_t          flush_cnt;
    fir_pkg::tap_idx_t          wr_ptr;
    fir_pkg::tap_cnt_t          k_cnt;
    fir_pkg::data_t             x_cnt;
    fir_pkg::data_t             y_cnt;
    fir_pkg::data_t             x_latch;
    fir_pkg::data_t             mul_reg;
    fir_pkg::data_t             acc;
    fir_pkg::data_t             sum;
    fir_pkg::data_t             out_buf;
    logic                       out_full;
    logic [fir_pkg::TAP_IDX_W:0] x_back;
    logic                       ss_fire;
    logic                       out_pop;
    logic                       out_free;
    logic                       flush_last;
    logic                       mac_last;

    assign ss_tready = (state == fir_pkg::ENG_WAIT_X) && (x_cnt < data_length);
    assign ss_fire   = ss_tvalid && ss_tready;

    // output buffer drives the stream
    assign sm_tvalid = out_full;
    assign sm_tdata  = out_buf;
    assign sm_tlast  = out_full && (y_cnt == data_length - 1'b1);
    assign out_pop   = out_full && sm_tready;
    assign out_free  = !out_full || out_pop;

    // last word of the ram
    assign flush_last = (flush_cnt == '1);
    // tap_num reads plus two drain cycles
    assign mac_last   = (k_cnt == tap_num + 1'b1);
    assign sum        = acc + mul_reg;

    // sample k places back, modulo tap_num
    always_comb begin
        if ({1'b0, wr_ptr} >= k_cnt) begin
            x_back = {1'b0, wr_ptr} - k_cnt;
        end else begin
            x_back = {1'b0, wr_ptr} + tap_num - k_cnt;
        end
    end

    assign x_raddr   = x_back[fir_pkg::TAP_IDX_W-1:0];
    assign tap_raddr = k_cnt[fir_pkg::TAP_IDX_W-1:0];

    // sample ram write side
    always_comb begin
        x_we    = 1'b0;
        x_waddr = wr_ptr;
        x_wdata = x_latch;
        if (state == fir_pkg::ENG_FLUSH) begin
            x_we    = 1'b1;
            x_waddr = flush_cnt;
            x_wdata = '0;
        end else if (state == fir_pkg::ENG_WRITE_X) begin
            x_we = 1'b1;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state     <= fir_pkg::ENG_IDLE;
            flush_cnt <= '0;
            wr_ptr    <= '0;
            k_cnt     <= '0;
            x_cnt     <= '0;
            y_cnt     <= '0;
            out_full  <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= out_pop && sm_tlast;
            if (out_pop) begin
                y_cnt    <= y_cnt + 1'b1;
                out_full <= 1'b0;
            end
            if (ss_fire) begin
                x_cnt <= x_cnt + 1'b1;
            end
            case (state)
                fir_pkg::ENG_IDLE: begin
                    if (start) begin
                        state     <= fir_pkg::ENG_FLUSH;
                        flush_cnt <= '0;
                        wr_ptr    <= '0;
                        x_cnt     <= '0;
                        y_cnt     <= '0;
                    end
                end
                fir_pkg::ENG_FLUSH: begin
                    flush_cnt <= flush_cnt + 1'b1;
                    if (flush_last) begin
                        state <= fir_pkg::ENG_WAIT_X;
                    end
                end
                fir_pkg::ENG_WAIT_X: begin
                    if (ss_fire) begin
                        state <= fir_pkg::ENG_WRITE_X;
                    end else if (out_pop && sm_tlast) begin
                        state <= fir_pkg::ENG_IDLE;
                    end
                end
                fir_pkg::ENG_WRITE_X: begin
                    k_cnt <= '0;
                    state <= fir_pkg::ENG_MAC;
                end
                fir_pkg::ENG_MAC: begin
                    if (mac_last) begin
                        if ({1'b0, wr_ptr} == tap_num - 1'b1) begin
                            wr_ptr <= '0;
                        end else begin
                            wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (out_free) begin
                            out_full <= 1'b1;
                            state    <= fir_pkg::ENG_WAIT_X;
                        end else begin
                            state <= fir_pkg::ENG_HOLD;
                        end
                    end else begin
                        k_cnt <= k_cnt + 1'b1;
                    end
                end
                fir_pkg::ENG_HOLD: begin
                    if (out_free) begin
                        out_full <= 1'b1;
                        state    <= fir_pkg::ENG_WAIT_X;
                    end
                end
                default: begin
                    state <= fir_pkg::ENG_IDLE;
                end
            endcase
        end
    end

    // datapath, ram outputs are the registered operands
    always_ff @(posedge axis_clk) begin
        if (ss_fire) begin
            x_latch <= ss_tdata;
        end
        mul_reg <= tap_rdata * x_rdata;
        if (state == fir_pkg::ENG_WRITE_X) begin
            acc <= '0;
        end else if ((state == fir_pkg::ENG_MAC) && (k_cnt >= 2)) begin
            // products lag the read index by two
            acc <= sum;
        end
        if ((state == fir_pkg::ENG_MAC) && mac_last && out_free) begin
            out_buf <= sum;
        end else if ((state == fir_pkg::ENG_HOLD) && out_free) begin
            out_buf <= acc;
        end
    end

endmodule

// ==== src/fir_pkg.sv ====
package fir_pkg;

    // word and address widths
    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 12;
    localparam int MAX_TAPS  = 32;
    localparam int TAP_IDX_W = $clog2(MAX_TAPS);

    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [TAP_IDX_W-1:0] tap_idx_t;
    // one bit wider than an index so that 32 fits
    typedef logic [TAP_IDX_W:0]   tap_cnt_t;

    // register map
    localparam addr_t ADDR_AP_CTRL  = 12'h000;
    localparam addr_t ADDR_DATA_LEN = 12'h010;
    localparam addr_t ADDR_TAP_NUM  = 12'h014;
    localparam addr_t ADDR_TAP_BASE = 12'h080;
    localparam addr_t ADDR_TAP_LAST = 12'h0FF;

    // ap_ctrl bit positions
    localparam int AP_START_BIT = 0;
    localparam int AP_DONE_BIT  = 1;
    localparam int AP_IDLE_BIT  = 2;

    // returned for anything not mapped
    localparam data_t RDATA_NONE = 32'hFFFF_FFFF;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_RUN,
        CTRL_DONE
    } ctrl_state_e;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_FLUSH,
        ENG_WAIT_X,
        ENG_WRITE_X,
        ENG_MAC,
        ENG_HOLD
    } engine_state_e;

endpackage

// ==== src/fir_top.sv ====
`timescale 1ns/10ps

module fir_top (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    input  logic           awvalid,
    output logic           awready,
    input  logic           wvalid,
    output logic           wready,
    input  fir_pkg::addr_t awaddr,
    input  fir_pkg::data_t wdata,
    input  logic           arvalid,
    output logic           arready,
    input  fir_pkg::addr_t araddr,
    output logic           rvalid,
    input  logic           rready,
    output fir_pkg::data_t rdata,
    input  logic           ss_tvalid,
    output logic           ss_tready,
    input  fir_pkg::data_t ss_tdata,
    output logic           sm_tvalid,
    input  logic           sm_tready,
    output fir_pkg::data_t sm_tdata,
    output logic           sm_tlast
);

    logic              start;
    logic              done;
    fir_pkg::data_t    data_length;
    fir_pkg::tap_cnt_t tap_num;

    // coefficient ram ports
    logic              tap_we;
    fir_pkg::tap_idx_t tap_waddr;
    fir_pkg::data_t    tap_wdata;
    fir_pkg::tap_idx_t tap_raddr;
    fir_pkg::data_t    tap_rdata;

    // delay line ram ports
    logic              x_we;
    fir_pkg::tap_idx_t x_waddr;
    fir_pkg::data_t    x_wdata;
    fir_pkg::tap_idx_t x_raddr;
    fir_pkg::data_t    x_rdata;

    axil_regs regs_i (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .awvalid     (awvalid),
        .awready     (awready),
        .wvalid      (wvalid),
        .wready      (wready),
        .awaddr      (awaddr),
        .wdata       (wdata),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .done        (done),
        .start       (start),
        .data_length (data_length),
        .tap_num     (tap_num),
        .tap_we      (tap_we),
        .tap_waddr   (tap_waddr),
        .tap_wdata   (tap_wdata)
    );

    fir_engine engine_i (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .start       (start),
        .data_length (data_length),
        .tap_num     (tap_num),
        .done        (done),
        .tap_raddr   (tap_raddr),
        .tap_rdata   (tap_rdata),
        .x_we        (x_we),
        .x_waddr     (x_waddr),
        .x_wdata     (x_wdata),
        .x_raddr     (x_raddr),
        .x_rdata     (x_rdata),
        .ss_tvalid   (ss_tvalid),
        .ss_tready   (ss_tready),
        .ss_tdata    (ss_tdata),
        .sm_tvalid   (sm_tvalid),
        .sm_tready   (sm_tready),
        .sm_tdata    (sm_tdata),
        .sm_tlast    (sm_tlast)
    );

    word_ram tap_ram_i (
        .axis_clk (axis_clk),
        .we       (tap_we),
        .waddr    (tap_waddr),
        .wdata    (tap_wdata),
        .raddr    (tap_raddr),
        .rdata    (tap_rdata)
    );

    word_ram sample_ram_i (
        .axis_clk (axis_clk),
        .we       (x_we),
        .waddr    (x_waddr),
        .wdata    (x_wdata),
        .raddr    (x_raddr),
        .rdata    (x_rdata)
    );

endmodule

// ==== src/word_ram.sv ====
`timescale 1ns/10ps

module word_ram (
    input  logic              axis_clk,
    input  logic              we,
    input  fir_pkg::tap_idx_t waddr,
    input  fir_pkg::data_t    wdata,
    input  fir_pkg::tap_idx_t raddr,
    output fir_pkg::data_t    rdata
);

    fir_pkg::data_t mem [fir_pkg::MAX_TAPS];

    // write port
    always_ff @(posedge axis_clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge axis_clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== tests/fir_tb_tasks.svh ====
`ifndef FIR_TB_TASKS_SVH
`define FIR_TB_TASKS_SVH

// stops the run when a handshake never arrives
task automatic abort_on_timeout(input string what);
    $display("Timeout at %0t ns: %s never arrived", $time, what);
    $display("SIMULATION FAILED");
    $fatal(1, "handshake timeout");
endtask

task automatic check_data(input fir_pkg::data_t got, input fir_pkg::data_t exp,
                          input string what);
    if (got !== exp) begin
        $display("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        $display("SIMULATION FAILED");
        $fatal(1, "data mismatch");
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        $display("SIMULATION FAILED");
        $fatal(1, "flag mismatch");
    end
endtask

// entered on a falling edge, returns on a falling edge
task automatic bus_write(input fir_pkg::addr_t addr, input fir_pkg::data_t value);
    int wait_cycles;
    awaddr      = addr;
    wdata       = value;
    awvalid     = 1'b1;
    wvalid      = 1'b1;
    wait_cycles = 0;
    @(negedge axis_clk);
    while (!(awready && wready)) begin
        wait_cycles++;
        if (wait_cycles > BUS_TIMEOUT) begin
            abort_on_timeout("awready/wready for a bus write");
        end
        @(negedge axis_clk);
    end
    // write lands on the rising edge in between
    @(negedge axis_clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
endtask

task automatic bus_read(input fir_pkg::addr_t addr, output fir_pkg::data_t value);
    int wait_cycles;
    araddr      = addr;
    arvalid     = 1'b1;
    wait_cycles = 0;
    @(negedge axis_clk);
    while (!arready) begin
        wait_cycles++;
        if (wait_cycles > BUS_TIMEOUT) begin
            abort_on_timeout("arready for a bus read");
        end
        @(negedge axis_clk);
    end
    @(negedge axis_clk);
    arvalid     = 1'b0;
    wait_cycles = 0;
    while (!rvalid) begin
        wait_cycles++;
        if (wait_cycles > BUS_TIMEOUT) begin
            abort_on_timeout("rvalid for a bus read");
        end
        @(negedge axis_clk);
    end
    value  = rdata;
    rready = 1'b1;
    @(negedge axis_clk);
    rready = 1'b0;
endtask

`endif

// ==== tests/fir_tb.sv ====
`timescale 1ns/10ps

module fir_tb;

    localparam int BUS_TIMEOUT    = 64;
    localparam int STREAM_TIMEOUT = 4000;

    logic           axis_clk;
    logic           axis_rst_n;
    logic           awvalid;
    logic           awready;
    logic           wvalid;
    logic           wready;
    fir_pkg::addr_t awaddr;
    fir_pkg::data_t wdata;
    logic           arvalid;
    logic           arready;
    fir_pkg::addr_t araddr;
    logic           rvalid;
    logic           rready;
    fir_pkg::data_t rdata;
    logic           ss_tvalid;
    logic           ss_tready;
    fir_pkg::data_t ss_tdata;
    logic           sm_tvalid;
    logic           sm_tready;
    fir_pkg::data_t sm_tdata;
    logic           sm_tlast;

    // reference model state
    fir_pkg::data_t coef [fir_pkg::MAX_TAPS];
    fir_pkg::data_t samples [$];
    fir_pkg::data_t expected [$];
    int             taps;

    fir_top UUT (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .wvalid     (wvalid),
        .wready     (wready),
        .awaddr     (awaddr),
        .wdata      (wdata),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tready  (ss_tready),
        .ss_tdata   (ss_tdata),
        .sm_tvalid  (sm_tvalid),
        .sm_tready  (sm_tready),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast)
    );

    `include "fir_tb_tasks.svh"

    initial begin
        axis_clk = 1'b0;
        forever #5 axis_clk = ~axis_clk;
    end

    // y[n] is the sum of h[k] * x[n-k] wrapped to 32 bits
    function automatic fir_pkg::data_t compute_expected(input int n);
        fir_pkg::data_t acc;
        acc = '0;
        for (int k = 0; k < taps; k++) begin
            // samples before the run are zero
            if (n - k >= 0) begin
                acc = acc + coef[k] * samples[n - k];
            end
        end
        return acc;
    endfunction

    function automatic void prepare_model(input int tap_count, input int len);
        taps = tap_count;
        samples.delete();
        expected.delete();
        for (int k = 0; k < fir_pkg::MAX_TAPS; k++) begin
            coef[k] = $urandom;
        end
        for (int n = 0; n < len; n++) begin
            samples.push_back($urandom);
        end
        for (int n = 0; n < len; n++) begin
            expected.push_back(compute_expected(n));
        end
    endfunction

    // input stream with random gaps
    task automatic send_samples(input int count);
        int wait_cycles;
        for (int idx = 0; idx < count; idx++) begin
            if ($urandom % 3 == 0) begin
                ss_tvalid = 1'b0;
                repeat ($urandom % 4 + 1) @(negedge axis_clk);
            end
            ss_tvalid   = 1'b1;
            ss_tdata    = samples[idx];
            wait_cycles = 0;
            while (!ss_tready) begin
                wait_cycles++;
                if (wait_cycles > STREAM_TIMEOUT) begin
                    abort_on_timeout("ss_tready for an input sample");
                end
                @(negedge axis_clk);
            end
            @(negedge axis_clk);
        end
        ss_tvalid = 1'b0;
    endtask

    // output stream with random stalls
    task automatic receive_results(input int count);
        int idx;
        int wait_cycles;
        idx         = 0;
        wait_cycles = 0;
        while (idx < count) begin
            sm_tready = ($urandom % 4) != 0;
            if (sm_tvalid && sm_tready) begin
                check_data(sm_tdata, expected[idx], $sformatf("sm_tdata word %0d", idx));
                check_flag(sm_tlast, idx == count - 1, $sformatf("sm_tlast word %0d", idx));
                idx++;
                wait_cycles = 0;
            end else begin
                wait_cycles++;
                if (wait_cycles > STREAM_TIMEOUT) begin
                    abort_on_timeout("sm_tvalid for an output word");
                end
            end
            @(negedge axis_clk);
        end
        sm_tready = 1'b0;
    endtask

    task automatic run_filter(input int tap_count, input int len);
        fir_pkg::data_t word;
        int             polls;
        prepare_model(tap_count, len);
        bus_write(fir_pkg::ADDR_TAP_NUM, fir_pkg::data_t'(tap_count));
        bus_write(fir_pkg::ADDR_DATA_LEN, fir_pkg::data_t'(len));
        for (int k = 0; k < tap_count; k++) begin
            bus_write(fir_pkg::ADDR_TAP_BASE + fir_pkg::addr_t'(4 * k), coef[k]);
        end
        bus_write(fir_pkg::ADDR_AP_CTRL, 32'h0000_0001);

        // configuration is frozen while running
        bus_write(fir_pkg::ADDR_DATA_LEN, fir_pkg::data_t'(len + 5));
        bus_read(fir_pkg::ADDR_DATA_LEN, word);
        check_data(word, fir_pkg::data_t'(len), "data_length during run");

        fork
            send_samples(len);
            receive_results(len);
        join

        polls = 0;
        bus_read(fir_pkg::ADDR_AP_CTRL, word);
        while (!word[fir_pkg::AP_DONE_BIT] && !word[fir_pkg::AP_IDLE_BIT]) begin
            polls++;
            if (polls > BUS_TIMEOUT) begin
                abort_on_timeout("ap_done after the last output");
            end
            bus_read(fir_pkg::ADDR_AP_CTRL, word);
        end
        check_flag(word[fir_pkg::AP_DONE_BIT], 1'b1, "ap_done after run");
        check_flag(word[fir_pkg::AP_IDLE_BIT], 1'b0, "ap_idle after run");
        // the done read returns the block to idle
        bus_read(fir_pkg::ADDR_AP_CTRL, word);
        check_flag(word[fir_pkg::AP_DONE_BIT], 1'b0, "ap_done after done read");
        check_flag(word[fir_pkg::AP_IDLE_BIT], 1'b1, "ap_idle after done read");
    endtask

    initial begin
        int             seed_val;
        int             taps_a;
        int             taps_b;
        fir_pkg::data_t word;
        seed_val   = $urandom(24638);
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        wvalid     = 1'b0;
        awaddr     = '0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        sm_tready  = 1'b0;
        repeat (2) @(negedge axis_clk);
        axis_rst_n = 1'b1;

        check_flag(awready, 1'b0, "awready after reset");
        check_flag(wready, 1'b0, "wready after reset");
        check_flag(arready, 1'b0, "arready after reset");
        check_flag(rvalid, 1'b0, "rvalid after reset");
        check_flag(ss_tready, 1'b0, "ss_tready after reset");
        check_flag(sm_tvalid, 1'b0, "sm_tvalid after reset");

        bus_read(fir_pkg::ADDR_AP_CTRL, word);
        check_flag(word[fir_pkg::AP_START_BIT], 1'b0, "ap_start after reset");
        check_flag(word[fir_pkg::AP_DONE_BIT], 1'b0, "ap_done after reset");
        check_flag(word[fir_pkg::AP_IDLE_BIT], 1'b1, "ap_idle after reset");

        // register readback and unmapped reads
        bus_write(fir_pkg::ADDR_DATA_LEN, 32'h0000_0123);
        bus_read(fir_pkg::ADDR_DATA_LEN, word);
        check_data(word, 32'h0000_0123, "data_length readback");
        bus_write(fir_pkg::ADDR_TAP_NUM, 32'd17);
        bus_read(fir_pkg::ADDR_TAP_NUM, word);
        check_data(word, 32'd17, "tap_num readback");
        bus_read(fir_pkg::ADDR_TAP_BASE, word);
        check_data(word, fir_pkg::RDATA_NONE, "coefficient read");
        bus_read(12'h040, word);
        check_data(word, fir_pkg::RDATA_NONE, "unmapped read");

        // at least two taps so the first run leaves stale history behind
        taps_a = 2 + $urandom % 31;
        run_filter(taps_a, 24 + $urandom % 25);

        // another tap count of two or more reads that stale history
        taps_b = ((taps_a - 2 + 1 + $urandom % 30) % 31) + 2;
        run_filter(taps_b, 24 + $urandom % 25);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
